// ==== logic/isaPkg.sv ====
package isaPkg;

    localparam int instrWidth = 32;
    localparam int opcodeWidth = 5;
    localparam int regIndexWidth = 4;
    localparam int constWidth = 19;
    localparam int condWidth = 2;

    // Three register fields, low bits unused
    typedef struct packed {
        logic [opcodeWidth-1:0] opcode;
        logic [regIndexWidth-1:0] ra;
        logic [regIndexWidth-1:0] rb;
        logic [regIndexWidth-1:0] rc;
        logic [instrWidth-opcodeWidth-3*regIndexWidth-1:0] unused;
    } regFormat;

    // Two register fields and the signed constant
    typedef struct packed {
        logic [opcodeWidth-1:0] opcode;
        logic [regIndexWidth-1:0] ra;
        logic [regIndexWidth-1:0] rb;
        logic [constWidth-1:0] c;
    } immFormat;

    // Condition code sits in the low bits of the rb slot
    typedef struct packed {
        logic [opcodeWidth-1:0] opcode;
        logic [regIndexWidth-1:0] ra;
        logic [regIndexWidth-condWidth-1:0] spare;
        logic [condWidth-1:0] cond;
        logic [constWidth-1:0] c;
    } branchFormat;

    // One IR word, decoded per consumer
    typedef union packed {
        regFormat regFmt;
        immFormat immFmt;
        branchFormat brFmt;
    } instrWord;

endpackage

// ==== logic/datapathPkg.sv ====
package datapathPkg;

    localparam int wordWidth = 32;

    // Operation select for the ALU, five bits wide like the opcode field
    typedef enum logic [4:0] {
        aluAdd  = 5'd0,
        aluSub  = 5'd1,
        aluAnd  = 5'd2,
        aluOr   = 5'd3,
        aluShl  = 5'd4,
        aluShr  = 5'd5,
        aluShra = 5'd6,
        aluRol  = 5'd7,
        aluRor  = 5'd8,
        aluMul  = 5'd9,
        aluDiv  = 5'd10,
        aluNeg  = 5'd11,
        aluNot  = 5'd12,
        aluIncr = 5'd13
    } aluOp;

    // Branch conditions, tested against the bus value
    typedef enum logic [1:0] {
        condZero     = 2'd0,
        condNonZero  = 2'd1,
        condPositive = 2'd2,
        condNegative = 2'd3
    } condCode;

endpackage

// ==== logic/selectEncode.sv ====
module selectEncode (
    input  isaPkg::instrWord instr,
    input  logic gra,
    input  logic grb,
    input  logic grc,
    input  logic rIn,
    input  logic rOut,
    input  logic baOut,
    output logic [(2**isaPkg::regIndexWidth)-1:0] writeEnable,
    output logic [isaPkg::regIndexWidth-1:0] readIndex,
    output logic readZero,
    output logic [$bits(isaPkg::instrWord)-1:0] constExt
);
    import isaPkg::*;

    logic [regIndexWidth-1:0] fieldIndex;

    // Field select, only one of gra/grb/grc is raised per step
    always_comb begin
        if (gra) begin
            fieldIndex = instr.regFmt.ra;
        end else if (grb) begin
            fieldIndex = instr.regFmt.rb;
        end else if (grc) begin
            fieldIndex = instr.regFmt.rc;
        end else begin
            fieldIndex = '0;
        end
    end

    // One-hot register load
    always_comb begin
        writeEnable = '0;
        if (rIn) begin
            writeEnable[fieldIndex] = 1'b1;
        end
    end

    // Read port idles at index 0 when nothing drives the bus from the file
    assign readIndex = (rOut || baOut) ? fieldIndex : '0;

    // Base-address reads treat R0 as a constant zero
    assign readZero = baOut && (fieldIndex == '0);

    assign constExt = {{($bits(instrWord)-constWidth){instr.immFmt.c[constWidth-1]}},
                       instr.immFmt.c};

endmodule

// ==== logic/registerFile.sv ====
module registerFile (
    input  logic clk,
    input  logic rst,
    input  logic [15:0] writeEnable,
    input  logic [3:0] readIndex,
    input  logic readZero,
    input  logic [datapathPkg::wordWidth-1:0] busData,
    output logic [datapathPkg::wordWidth-1:0] readData
);
    import datapathPkg::*;

    localparam int numRegs = 16;

    logic [wordWidth-1:0] regs [numRegs];

    // All sixteen load from the bus under their own enable
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < numRegs; i++) begin
                regs[i] <= '0;
            end
        end else begin
            for (int i = 0; i < numRegs; i++) begin
                if (writeEnable[i]) begin
                    regs[i] <= busData;
                end
            end
        end
    end

    // R0 reads as zero only for base-address use
    assign readData = readZero ? '0 : regs[readIndex];

endmodule

// ==== logic/alu.sv ====
module alu (
    input  datapathPkg::aluOp op,
    input  logic [datapathPkg::wordWidth-1:0] a,
    input  logic [datapathPkg::wordWidth-1:0] b,
    output logic [2*datapathPkg::wordWidth-1:0] result
);
    import datapathPkg::*;

    localparam int shiftWidth = $clog2(wordWidth);

    logic [shiftWidth-1:0] shamt;
    logic [2*wordWidth-1:0] rotLeft;
    logic [2*wordWidth-1:0] rotRight;
    logic signed [2*wordWidth-1:0] product;
    logic [wordWidth-1:0] quotient;
    logic [wordWidth-1:0] remainder;
    logic [wordWidth-1:0] low;

    // Shift count from the low bits of the bus operand
    assign shamt = b[shiftWidth-1:0];

    // Rotations through a doubled word
    assign rotLeft = {a, a} << shamt;
    assign rotRight = {a, a} >> shamt;

    // Signed full-width product
    assign product = $signed(a) * $signed(b);

    // Signed divide, divisor zero gives all-ones quotient
    always_comb begin
        if (b == '0) begin
            quotient = '1;
            remainder = a;
        end else begin
            quotient = $signed(a) / $signed(b);
            remainder = $signed(a) % $signed(b);
        end
    end

    // Single-word operations; neg, not and incr act on the bus operand only
    always_comb begin
        case (op)
            aluAdd:  low = a + b;
            aluSub:  low = a - b;
            aluAnd:  low = a & b;
            aluOr:   low = a | b;
            aluShl:  low = a << shamt;
            aluShr:  low = a >> shamt;
            aluShra: low = $signed(a) >>> shamt;
            aluRol:  low = rotLeft[2*wordWidth-1:wordWidth];
            aluRor:  low = rotRight[wordWidth-1:0];
            aluNeg:  low = -b;
            aluNot:  low = ~b;
            aluIncr: low = b + 1'b1;
            default: low = '0;
        endcase
    end

    // Remainder goes high, quotient low
    always_comb begin
        case (op)
            aluMul:  result = product;
            aluDiv:  result = {remainder, quotient};
            default: result = {{wordWidth{1'b0}}, low};
        endcase
    end

endmodule

// ==== logic/memoryInterface.sv ====
module memoryInterface #(
    parameter int addrWidth = 9
) (
    input  logic clk,
    input  logic rst,
    input  logic marIn,
    input  logic mdrIn,
    input  logic read,
    input  logic write,
    input  logic [datapathPkg::wordWidth-1:0] busData,
    output logic [datapathPkg::wordWidth-1:0] mdrData
);
    import datapathPkg::*;

    localparam int depth = 2 ** addrWidth;

    logic [addrWidth-1:0] mar;
    logic [wordWidth-1:0] mdr;
    logic [wordWidth-1:0] ram [depth];
    logic [wordWidth-1:0] ramData;

    // Asynchronous read at the current address
    assign ramData = ram[mar];

    // Only the low address bits of the bus are kept
    always_ff @(posedge clk) begin
        if (rst) begin
            mar <= '0;
        end else if (marIn) begin
            mar <= busData[addrWidth-1:0];
        end
    end

    // MDR takes memory on a read step, the bus otherwise
    always_ff @(posedge clk) begin
        if (rst) begin
            mdr <= '0;
        end else if (mdrIn) begin
            mdr <= read ? ramData : busData;
        end
    end

    // Write stores the MDR value present before this edge
    always_ff @(posedge clk) begin
        if (write) begin
            ram[mar] <= mdr;
        end
    end

    assign mdrData = mdr;

endmodule

// ==== logic/conditionLogic.sv ====
module conditionLogic (
    input  logic clk,
    input  logic rst,
    input  logic conIn,
    input  datapathPkg::condCode cond,
    input  logic [datapathPkg::wordWidth-1:0] busData,
    output logic conFlag
);
    import datapathPkg::*;

    logic isZero;
    logic isNegative;
    logic outcome;

    assign isZero = (busData == '0);
    assign isNegative = busData[wordWidth-1];

    // Positive means sign bit clear, zero included
    always_comb begin
        case (cond)
            condZero:     outcome = isZero;
            condNonZero:  outcome = !isZero;
            condPositive: outcome = !isNegative;
            condNegative: outcome = isNegative;
            default:      outcome = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            conFlag <= 1'b0;
        end else if (conIn) begin
            conFlag <= outcome;
        end
    end

endmodule

// ==== logic/datapath.sv ====
module datapath #(
    parameter int addrWidth = 9
) (
    input  logic clk,
    input  logic rst,
    input  logic pcIn, irIn, yIn, zIn, hiIn, loIn,
    input  logic marIn, mdrIn, outPortIn,
    input  logic pcOut, zHighOut, zLowOut, hiOut, loOut,
    input  logic mdrOut, inPortOut, cOut,
    input  logic read, write,
    input  logic gra, grb, grc, rIn, rOut, baOut,
    input  logic conIn,
    input  datapathPkg::aluOp aluOp,
    input  logic [datapathPkg::wordWidth-1:0] inPortData,
    output logic [datapathPkg::wordWidth-1:0] outPortData,
    output logic [datapathPkg::wordWidth-1:0] busData,
    output logic conFlag
);
    import isaPkg::*;
    import datapathPkg::*;

    logic [wordWidth-1:0] pc, y, hi, lo, inPortReg;
    instrWord ir;
    logic [2*wordWidth-1:0] z;
    logic [2*wordWidth-1:0] aluResult;
    logic [(2**regIndexWidth)-1:0] writeEnable;
    logic [regIndexWidth-1:0] readIndex;
    logic readZero;
    logic [wordWidth-1:0] regData, constExt, mdrData;

    // Special registers, each loaded from the bus by its strobe
    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= '0;
            ir <= '0;
            y <= '0;
            z <= '0;
            hi <= '0;
            lo <= '0;
            outPortData <= '0;
        end else begin
            if (pcIn) pc <= busData;
            if (irIn) ir <= busData;
            if (yIn) y <= busData;
            if (zIn) z <= aluResult;
            if (hiIn) hi <= busData;
            if (loIn) lo <= busData;
            if (outPortIn) outPortData <= busData;
        end
    end

    // Input port is sampled every cycle, so the bus sees it one cycle late
    always_ff @(posedge clk) begin
        if (rst) begin
            inPortReg <= '0;
        end else begin
            inPortReg <= inPortData;
        end
    end

    // One-hot AND-OR bus, zero when idle
    assign busData = ({wordWidth{pcOut}} & pc)
                   | ({wordWidth{zHighOut}} & z[2*wordWidth-1:wordWidth])
                   | ({wordWidth{zLowOut}} & z[wordWidth-1:0])
                   | ({wordWidth{hiOut}} & hi)
                   | ({wordWidth{loOut}} & lo)
                   | ({wordWidth{mdrOut}} & mdrData)
                   | ({wordWidth{inPortOut}} & inPortReg)
                   | ({wordWidth{rOut | baOut}} & regData)
                   | ({wordWidth{cOut}} & constExt);

    selectEncode i_selectEncode (
        .instr(ir), .gra(gra), .grb(grb), .grc(grc), .rIn(rIn), .rOut(rOut), .baOut(baOut),
        .writeEnable(writeEnable), .readIndex(readIndex), .readZero(readZero),
        .constExt(constExt)
    );

    registerFile i_registerFile (
        .clk(clk), .rst(rst), .writeEnable(writeEnable), .readIndex(readIndex),
        .readZero(readZero), .busData(busData), .readData(regData)
    );

    alu i_alu (.op(aluOp), .a(y), .b(busData), .result(aluResult));

    memoryInterface #(.addrWidth(addrWidth)) i_memoryInterface (
        .clk(clk), .rst(rst), .marIn(marIn), .mdrIn(mdrIn), .read(read), .write(write),
        .busData(busData), .mdrData(mdrData)
    );

    // Condition field taken from the branch view of IR
    conditionLogic i_conditionLogic (
        .clk(clk), .rst(rst), .conIn(conIn), .cond(condCode'(ir.brFmt.cond)),
        .busData(busData), .conFlag(conFlag)
    );

endmodule

// ==== tests/datapath_sva.sv ====
module datapathSva #(
    parameter int addrWidth = 9
) (
    input logic clk, rst, irIn, yIn, zIn, pcIn, hiIn, loIn, marIn, mdrIn, outPortIn, conIn,
    input logic pcOut, zHighOut, zLowOut, hiOut, loOut, mdrOut, inPortOut, cOut,
    input logic read, write, gra, grb, grc, rIn, rOut, baOut,
    input datapathPkg::aluOp aluOp,
    input logic [datapathPkg::wordWidth-1:0] inPortData, busData, outPortData,
    input logic conFlag
);
    import isaPkg::*;
    import datapathPkg::*;

    int errorCount = 0;
    instrWord irShadow;
    logic [wordWidth-1:0] yShadow, pcShadow, mdrShadow, outShadow;
    logic [wordWidth-1:0] hiShadow, loShadow, inShadow;
    logic [wordWidth-1:0] expectedBus;
    logic [2*wordWidth-1:0] zShadow;
    logic [wordWidth-1:0] regShadow [16];
    logic [wordWidth-1:0] ramShadow [2**addrWidth];
    logic [addrWidth-1:0] marShadow;
    logic [regIndexWidth-1:0] selIndex;
    logic conShadow;
    logic condNow;

    // Z contents after zIn, with Y as the first operand and the bus as the second
    function automatic logic [2*wordWidth-1:0] expectedZ(datapathPkg::aluOp op,
                                                         logic [wordWidth-1:0] a,
                                                         logic [wordWidth-1:0] b);
        logic signed [2*wordWidth-1:0] wideA;
        logic signed [2*wordWidth-1:0] wideB;
        logic [4:0] count;
        wideA = {{wordWidth{a[wordWidth-1]}}, a};
        wideB = {{wordWidth{b[wordWidth-1]}}, b};
        count = b[4:0];
        case (op)
            aluAdd:  return {32'h0, a + b};
            aluSub:  return {32'h0, a - b};
            aluAnd:  return {32'h0, a & b};
            aluOr:   return {32'h0, a | b};
            aluShl:  return {32'h0, a << count};
            aluShr:  return {32'h0, a >> count};
            aluShra: return {32'h0, $signed(a) >>> count};
            aluRol:  return {32'h0, (a << count) | (a >> (32 - count))};
            aluRor:  return {32'h0, (a >> count) | (a << (32 - count))};
            aluMul:  return wideA * wideB;
            // Remainder high, quotient low
            aluDiv:  return (b == '0) ? {a, 32'hffff_ffff}
                                      : {32'(wideA % wideB), 32'(wideA / wideB)};
            aluNeg:  return {32'h0, -b};
            aluNot:  return {32'h0, ~b};
            aluIncr: return {32'h0, b + 32'd1};
            default: return '0;
        endcase
    endfunction

    assign selIndex = gra ? irShadow.regFmt.ra : grb ? irShadow.regFmt.rb
                    : grc ? irShadow.regFmt.rc : '0;

    // Branch condition from the IR branch view
    assign condNow = (irShadow.brFmt.cond == condZero) ? (busData == '0)
                   : (irShadow.brFmt.cond == condNonZero) ? (busData != '0)
                   : (irShadow.brFmt.cond == condPositive) ? !busData[wordWidth-1]
                   : busData[wordWidth-1];

    // Bus value predicted for the active source
    always_comb begin
        expectedBus = '0;
        case (1'b1)
            pcOut:     expectedBus = pcShadow;
            zHighOut:  expectedBus = zShadow[2*wordWidth-1:wordWidth];
            zLowOut:   expectedBus = zShadow[wordWidth-1:0];
            hiOut:     expectedBus = hiShadow;
            loOut:     expectedBus = loShadow;
            mdrOut:    expectedBus = mdrShadow;
            inPortOut: expectedBus = inShadow;
            cOut:      expectedBus = $signed(irShadow.immFmt.c);
            rOut:      expectedBus = regShadow[selIndex];
            baOut:     expectedBus = (selIndex == '0) ? '0 : regShadow[selIndex];
            // Idle bus reads zero
            default:   expectedBus = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            irShadow <= '0;
            yShadow <= '0;
            zShadow <= '0;
            pcShadow <= '0;
            hiShadow <= '0;
            loShadow <= '0;
            inShadow <= '0;
            marShadow <= '0;
            mdrShadow <= '0;
            outShadow <= '0;
            conShadow <= 1'b0;
            for (int i = 0; i < 16; i++) begin
                regShadow[i] <= '0;
            end
        end else begin
            if (irIn) irShadow <= busData;
            if (yIn) yShadow <= busData;
            if (zIn) zShadow <= expectedZ(aluOp, yShadow, busData);
            if (pcIn) pcShadow <= busData;
            if (hiIn) hiShadow <= busData;
            if (loIn) loShadow <= busData;
            inShadow <= inPortData;
            if (marIn) marShadow <= busData[addrWidth-1:0];
            if (mdrIn) mdrShadow <= read ? ramShadow[marShadow] : busData;
            if (write) ramShadow[marShadow] <= mdrShadow;
            if (rIn) regShadow[selIndex] <= busData;
            if (outPortIn) outShadow <= busData;
            if (conIn) conShadow <= condNow;
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        $onehot0({pcOut, zHighOut, zLowOut, hiOut, loOut, mdrOut, inPortOut, cOut, rOut, baOut}))
        else begin
            errorCount++;
            $error("More than one source drives the bus in the same cycle");
        end

    assert property (@(posedge clk) disable iff (rst) busData == expectedBus)
        else begin
            errorCount++;
            $error("ERROR busData=%h expected %h", $sampled(busData), $sampled(expectedBus));
        end

    assert property (@(posedge clk) disable iff (rst)
        outPortData == outShadow && conFlag == conShadow)
        else begin
            errorCount++;
            $error("ERROR outPortData=%h expected %h, conFlag=%h expected %h",
                   $sampled(outPortData), $sampled(outShadow), $sampled(conFlag),
                   $sampled(conShadow));
        end

endmodule

bind datapath datapathSva #(.addrWidth(addrWidth)) i_sva (.*);

// ==== tests/datapathTb.sv ====
module datapathTb;
    import datapathPkg::*;

    localparam int seed = 70059;
    // About 345 cycles of micro-steps plus margin
    localparam int maxCycles = 400;

    logic clk = 1'b0;
    logic rst = 1'b1;
    logic pcIn, irIn, yIn, zIn, hiIn, loIn, marIn, mdrIn, outPortIn;
    logic pcOut, zHighOut, zLowOut, hiOut, loOut, mdrOut, inPortOut, cOut;
    logic read, write, gra, grb, grc, rIn, rOut, baOut, conIn;
    datapathPkg::aluOp aluOp;
    logic [wordWidth-1:0] inPortData, outPortData, busData;
    logic conFlag;
    int cycles = 0;
    int xErrors = 0;
    int timeouts = 0;

    datapath i_dut (.*);

    always #2 clk = ~clk;

    task automatic clearStrobes();
        {pcIn, irIn, yIn, zIn, hiIn, loIn, marIn, mdrIn, outPortIn} = '0;
        {pcOut, zHighOut, zLowOut, hiOut, loOut, mdrOut, inPortOut, cOut} = '0;
        {read, write, gra, grb, grc, rIn, rOut, baOut, conIn} = '0;
    endtask

    // Holds the strobes for one cycle
    task automatic endStep();
        @(negedge clk);
        clearStrobes();
    endtask

    // In-port register adds a cycle before inPortOut can show the word
    task automatic fromPort(input logic [wordWidth-1:0] value);
        inPortData = value;
        @(negedge clk);
        inPortOut = 1'b1;
    endtask

    task automatic storeWord(input logic [wordWidth-1:0] addr,
                             input logic [wordWidth-1:0] data);
        fromPort(addr);
        marIn = 1'b1;
        endStep();
        fromPort(data);
        mdrIn = 1'b1;
        endStep();
        write = 1'b1;
        endStep();
    endtask

    task automatic reportAndFinish();
        int failures;
        failures = i_dut.i_sva.errorCount + xErrors + timeouts;
        $display("Assertion errors: %0d, unknown-value errors: %0d, timeouts: %0d",
                 i_dut.i_sva.errorCount, xErrors, timeouts);
        if (failures == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    endtask

    always @(posedge clk) begin
        cycles++;
        if (!rst && $isunknown({outPortData, busData, conFlag})) begin
            xErrors++;
            $display("Unknown value on a DUT output at cycle %0d", cycles);
        end
        if (cycles >= maxCycles) begin
            timeouts++;
            $display("Timeout: the test sequence did not finish within %0d cycles", maxCycles);
            reportAndFinish();
        end
    end

    initial begin
        logic [wordWidth-1:0] word;
        logic [wordWidth-1:0] addrs [8];
        void'($urandom(seed));
        inPortData = '0;
        aluOp = aluAdd;
        clearStrobes();
        repeat (5) @(negedge clk);
        rst = 1'b0;

        // Out port load, then a few cycles of hold
        fromPort($urandom);
        outPortIn = 1'b1;
        endStep();
        repeat (2) @(negedge clk);

        // Loads through ra, rb, rc, then rOut and baOut on each field
        for (int i = 0; i < 4; i++) begin
            word = $urandom;
            if (i == 0) begin
                word[26:23] = '0;
            end
            fromPort(word);
            irIn = 1'b1;
            endStep();
            for (int f = 0; f < 9; f++) begin
                if (f < 3) begin
                    fromPort($urandom);
                end
                {gra, grb, grc} = 3'b100 >> (f % 3);
                rIn = (f < 3);
                rOut = (f >= 3) && (f < 6);
                baOut = (f >= 6);
                endStep();
            end
        end

        // Every op once, a divide by zero, then random ops
        for (int i = 0; i < 18; i++) begin
            fromPort($urandom);
            yIn = 1'b1;
            endStep();
            fromPort((i == 14) ? '0 : $urandom);
            if (i < 14) begin
                aluOp = datapathPkg::aluOp'(i[4:0]);
            end else if (i == 14) begin
                aluOp = aluDiv;
            end else begin
                aluOp = datapathPkg::aluOp'(5'($urandom_range(13)));
            end
            zIn = 1'b1;
            endStep();
            // Both halves pass through LO and HI on their way back to the bus
            zLowOut = 1'b1;
            loIn = 1'b1;
            outPortIn = 1'b1;
            endStep();
            zHighOut = 1'b1;
            hiIn = 1'b1;
            endStep();
            hiOut = 1'b1;
            endStep();
            loOut = 1'b1;
            endStep();
        end

        for (int i = 0; i < 8; i++) begin
            addrs[i] = $urandom;
            storeWord(addrs[i], $urandom);
        end
        for (int i = 0; i < 8; i++) begin
            fromPort(addrs[i]);
            marIn = 1'b1;
            endStep();
            read = 1'b1;
            mdrIn = 1'b1;
            endStep();
            mdrOut = 1'b1;
            endStep();
        end

        // Fetch with address and increment in T0, new PC and read in T1, IR load in T2
        for (int i = 0; i < 2; i++) begin
            word = $urandom;
            fromPort(word);
            pcIn = 1'b1;
            endStep();
            storeWord(word, $urandom);
            pcOut = 1'b1;
            marIn = 1'b1;
            aluOp = aluIncr;
            zIn = 1'b1;
            endStep();
            zLowOut = 1'b1;
            pcIn = 1'b1;
            read = 1'b1;
            mdrIn = 1'b1;
            endStep();
            mdrOut = 1'b1;
            irIn = 1'b1;
            endStep();
            cOut = 1'b1;
            outPortIn = 1'b1;
            endStep();
            pcOut = 1'b1;
            endStep();
        end

        // Each condition on a zero bus, then on random values
        for (int i = 0; i < 8; i++) begin
            word = $urandom;
            word[20:19] = i[1:0];
            fromPort(word);
            irIn = 1'b1;
            endStep();
            fromPort((i < 4) ? '0 : $urandom);
            conIn = 1'b1;
            endStep();
        end

        repeat (2) @(negedge clk);
        reportAndFinish();
    end

endmodule

// ==== sources.f ====
logic/isaPkg.sv
logic/datapathPkg.sv
logic/selectEncode.sv
logic/registerFile.sv
logic/alu.sv
logic/memoryInterface.sv
logic/conditionLogic.sv
logic/datapath.sv
tests/datapath_sva.sv
tests/datapathTb.sv
